/* sources.f */
+incdir+src
+incdir+sim
src/vcu_pkg.sv
src/vcu_config.sv
src/vcu_opmode_decode.sv
src/vcu_ctrl_decode.sv
src/vcu_top.sv
sim/tb_vcu.sv

/* Makefile */
# Verilator flow for the vector control unit front end
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module vcu_top -f sources.f

sim:
	verilator --binary --timing --assert --top-module tb_vcu -f sources.f
	./obj_dir/Vtb_vcu > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then \
		echo "simulation failed"; \
		exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* sim/tb_vcu_ref.svh */
`ifndef TB_VCU_REF_SVH
`define TB_VCU_REF_SVH

// lcg step, 32 bit modulus
function automatic logic [31:0] lcg_next(input logic [31:0] s);
   return s * 32'd1664525 + 32'd1013904223;
endfunction

// elements per register group, lmul 5..7 are 1/8 .. 1/2
function automatic logic [31:0] ref_vlmax(input logic [2:0] sew, input logic [2:0] lmul);
   int elems;
   elems = (`VCU_VLEN / 8) / (1 << sew);   // elements in one register
   if (lmul < 3'd4)
      return 32'(elems * (1 << lmul));
   else if (lmul == 3'd4)
      return 32'd0;                         // reserved code
   else
      return 32'(elems / (1 << (8 - int'(lmul))));
endfunction

// alu opmode tables, integer and mv
function automatic vcu_pkg::alu_op_e ref_opmode(input int cls, input logic [5:0] f6);
   if (cls == `VCU_CLS_IVV || cls == `VCU_CLS_IVI || cls == `VCU_CLS_IVX)
   begin
      case (f6)
         6'h00, 6'h10, 6'h11, 6'h21, 6'h30, 6'h31: return vcu_pkg::add_op;
         6'h02, 6'h03, 6'h12, 6'h13, 6'h23:        return vcu_pkg::sub_op;
         6'h04, 6'h1A:                             return vcu_pkg::sltu_op;
         6'h05, 6'h1B:                             return vcu_pkg::slt_op;
         6'h06, 6'h1E:                             return vcu_pkg::sgtu_op;
         6'h07, 6'h1F:                             return vcu_pkg::sgt_op;
         6'h09:                                    return vcu_pkg::and_op;
         6'h0A:                                    return vcu_pkg::or_op;
         6'h0B:                                    return vcu_pkg::xor_op;
         6'h18:                                    return vcu_pkg::seq_op;
         6'h19:                                    return vcu_pkg::sneq_op;
         6'h1C:                                    return vcu_pkg::sleu_op;
         6'h1D:                                    return vcu_pkg::sle_op;
         6'h20:                                    return vcu_pkg::addu_op;
         6'h22:                                    return vcu_pkg::subu_op;
         6'h25:                                    return vcu_pkg::sll_op;
         6'h27:                                    return vcu_pkg::mul_op;
         6'h28, 6'h2A, 6'h2C, 6'h2E, 6'h2F:        return vcu_pkg::srl_op; // logical, clips
         6'h29, 6'h2B, 6'h2D:                      return vcu_pkg::sra_op;
         default:                                  return vcu_pkg::none_op;
      endcase
   end
   else if (cls == `VCU_CLS_MVV || cls == `VCU_CLS_MVX)
   begin
      case (f6)
         6'h00, 6'h09, 6'h31, 6'h35:               return vcu_pkg::add_op;
         6'h01, 6'h19:                             return vcu_pkg::and_op;
         6'h02, 6'h1A:                             return vcu_pkg::or_op;
         6'h03, 6'h1B:                             return vcu_pkg::xor_op;
         6'h04:                                    return vcu_pkg::sltu_op;
         6'h05:                                    return vcu_pkg::slt_op;
         6'h06:                                    return vcu_pkg::sgtu_op;
         6'h07:                                    return vcu_pkg::sgt_op;
         6'h08, 6'h30, 6'h34:                      return vcu_pkg::addu_op;
         6'h0A, 6'h32, 6'h36:                      return vcu_pkg::subu_op;
         6'h0B, 6'h33, 6'h37:                      return vcu_pkg::sub_op;
         6'h18:                                    return vcu_pkg::andnot_op;
         6'h1C:                                    return vcu_pkg::ornot_op;
         6'h1D:                                    return vcu_pkg::nand_op;
         6'h1E:                                    return vcu_pkg::nor_op;
         6'h1F:                                    return vcu_pkg::xnor_op;
         6'h24:                                    return vcu_pkg::mulhu_op;
         6'h25, 6'h3B:                             return vcu_pkg::mul_op;
         6'h26:                                    return vcu_pkg::mulhsu_op;
         6'h27:                                    return vcu_pkg::mulh_op;
         6'h29, 6'h2D, 6'h3D:                      return vcu_pkg::mul_add_op;
         6'h2B, 6'h2F:                             return vcu_pkg::mul_sub_op;
         6'h38:                                    return vcu_pkg::mulu_op;
         6'h3A:                                    return vcu_pkg::mulsu_op;
         6'h3C:                                    return vcu_pkg::mulu_add_op;
         6'h3E:                                    return vcu_pkg::mulus_add_op;
         6'h3F:                                    return vcu_pkg::mulsu_add_op;
         default:                                  return vcu_pkg::none_op;
      endcase
   end
   else
      return vcu_pkg::none_op;                // memory and config classes
endfunction

function automatic logic ref_reduction(input int cls, input logic [5:0] f6);
   return ((cls == `VCU_CLS_MVV || cls == `VCU_CLS_MVX) && f6[5:3] == 3'd0) ||
          (cls == `VCU_CLS_IVV && f6[5:3] == 3'd6);
endfunction

function automatic logic ref_is_slide(input int cls, input logic [5:0] f6);
   return (cls != `VCU_CLS_CFG) && (f6 == 6'h0E || f6 == 6'h0F);
endfunction

// fast when rs1 is one lane row of elements
function automatic logic ref_fast(input logic [2:0] sew, input logic [31:0] rs1);
   if (sew > 3'd2)
      return 1'b0;
   else
      return rs1 == 32'(`VCU_VLANE_NUM << (2 - int'(sew)));
endfunction

function automatic vcu_pkg::inst_type_e ref_inst_type(input int cls, input logic [5:0] f6);
   if (cls == `VCU_CLS_STORE)
      return vcu_pkg::inst_store;
   else if (cls == `VCU_CLS_ISTORE)
      return vcu_pkg::inst_istore;
   else if (cls == `VCU_CLS_LOAD)
      return vcu_pkg::inst_load;
   else if (cls == `VCU_CLS_ILOAD)
      return vcu_pkg::inst_iload;
   else if (ref_reduction(cls, f6))
      return vcu_pkg::inst_reduction;
   else if (ref_is_slide(cls, f6))
      return vcu_pkg::inst_slide;
   else if (cls == `VCU_CLS_CFG)
      return vcu_pkg::inst_config;
   else
      return vcu_pkg::inst_normal;
endfunction

function automatic vcu_pkg::op2_sel_e ref_op2_sel(input int cls);
   case (cls)
      `VCU_CLS_IVV, `VCU_CLS_MVV: return vcu_pkg::op2_vector;
      `VCU_CLS_IVX, `VCU_CLS_MVX: return vcu_pkg::op2_scalar;
      `VCU_CLS_IVI:               return vcu_pkg::op2_imm;
      default:                    return vcu_pkg::op2_none;
   endcase
endfunction

function automatic logic [1:0] ref_width(input int cls, input logic [5:0] f6,
                                         input logic [2:0] sew, input logic [31:0] rs1);
   if (ref_is_slide(cls, f6) && !ref_fast(sew, rs1))
      return 2'd1;                 // slow slide, byte wide
   else if (f6[5:4] == 2'b11)
      return 2'(sew + 3'd2);       // widening
   else
      return 2'(sew + 3'd1);
endfunction

// byte amount of a slide
function automatic logic [31:0] ref_slide_amt(input int cls, input logic [31:0] instr,
                                              input logic [31:0] rs1, input logic [2:0] sew);
   logic [31:0] amt;
   if (cls == `VCU_CLS_IVI)
      amt = 32'(instr[19:15]);
   else if (cls == `VCU_CLS_IVX)
      amt = rs1;
   else
      amt = 32'd1;                 // slide1up / slide1down
   return amt << sew;
endfunction

`endif

/* sim/tb_vcu.sv */
`timescale 1ns/1ns
`default_nettype none
`include "vcu_consts.svh"

module tb_vcu;

   `include "tb_vcu_ref.svh"

   logic                    clk;
   logic                    rstn;
   logic [`VCU_CLS_NUM-1:0] instr_vld_i;
   logic [31:0]             vector_instr_i;
   logic [`VCU_XLEN-1:0]    scalar_rs1_i;
   logic                    cmd_vld_o;
   logic [2:0]              sew_o;
   logic [2:0]              lmul_o;
   logic [`VCU_XLEN-1:0]    vl_o;
   vcu_pkg::alu_op_e        alu_opmode_o;
   vcu_pkg::inst_type_e     inst_type_o;
   vcu_pkg::op2_sel_e       op2_sel_o;
   logic                    reduction_op_o;
   logic [1:0]              wdata_width_o;
   logic                    vector_mask_o;
   logic [`VCU_XLEN-1:0]    alu_x_data_o;
   logic [4:0]              alu_imm_o;
   logic                    up_down_slide_o;
   logic                    slide_type_o;
   logic [`VCU_XLEN-1:0]    slide_amount_o;

   int          drv_idx;               // class driven this cycle, -1 idle
   logic [31:0] rng;
   string       test_name;
   int          err_value;
   int          err_other;             // timeouts

   // tb side capture register and vtype state
   logic        cap_vld;
   int          cap_idx;
   logic [31:0] cap_instr;
   logic [31:0] cap_rs1;
   logic [2:0]  m_sew  = 3'd2;         // e32 after reset
   logic [2:0]  m_lmul = 3'd0;
   logic [31:0] m_vl   = 32'd128;

   vcu_top DUT (.*);

   always #5 clk = ~clk;

   function automatic logic [31:0] rnd();
      rng = lcg_next(rng);
      return rng;
   endfunction

   always @(posedge clk)
   begin
      if (!rstn)
         cap_vld <= 1'b0;
      else
      begin
         cap_vld   <= (drv_idx >= 0);
         cap_idx   <= drv_idx;
         cap_instr <= vector_instr_i;
         cap_rs1   <= scalar_rs1_i;
      end
   end

   task automatic check_val(input string field, input logic [31:0] exp,
                            input logic [31:0] act);
      assert (act === exp)
      else
      begin
         $display("[FAIL] %s %s: expected %0h, actual %0h", test_name, field, exp, act);
         err_value++;
      end
   endtask

   // outputs against the model, then vtype update for a captured config
   task automatic compare_outputs();
      logic [5:0] f6;
      logic [2:0] n_sew;
      logic [2:0] n_lmul;
      f6 = cap_instr[31:26];
      check_val("sew_o", 32'(m_sew), 32'(sew_o));
      check_val("lmul_o", 32'(m_lmul), 32'(lmul_o));
      check_val("vl_o", m_vl, vl_o);
      check_val("cmd_vld_o", 32'(cap_vld), 32'(cmd_vld_o));
      if (cap_vld)
      begin
         check_val("alu_opmode_o", 32'(ref_opmode(cap_idx, f6)), 32'(alu_opmode_o));
         check_val("inst_type_o", 32'(ref_inst_type(cap_idx, f6)), 32'(inst_type_o));
         check_val("op2_sel_o", 32'(ref_op2_sel(cap_idx)), 32'(op2_sel_o));
         check_val("reduction_op_o", 32'(ref_reduction(cap_idx, f6)), 32'(reduction_op_o));
         check_val("wdata_width_o", 32'(ref_width(cap_idx, f6, m_sew, cap_rs1)),
                   32'(wdata_width_o));
         check_val("vector_mask_o", 32'(!cap_instr[25]), 32'(vector_mask_o));
         check_val("alu_x_data_o", cap_rs1, alu_x_data_o);
         check_val("alu_imm_o", 32'(cap_instr[19:15]), 32'(alu_imm_o));
         check_val("up_down_slide_o", 32'(f6 != 6'h0F), 32'(up_down_slide_o));
         check_val("slide_type_o", 32'(ref_fast(m_sew, cap_rs1)), 32'(slide_type_o));
         check_val("slide_amount_o", ref_slide_amt(cap_idx, cap_instr, cap_rs1, m_sew),
                   slide_amount_o);
         if (cap_idx == `VCU_CLS_CFG)   // visible after the next edge
         begin
            if (cap_instr[31:30] == 2'b10)
            begin
               n_lmul = cap_rs1[2:0];
               n_sew  = cap_rs1[5:3];
            end
            else
            begin
               n_lmul = {cap_instr[25], cap_instr[21:20]};
               n_sew  = cap_instr[24:22];
            end
            if (cap_instr[19:15] != 5'd0)
               m_vl = cap_rs1;          // avl from rs1
            else if (cap_instr[11:7] != 5'd0)
               m_vl = ref_vlmax(n_sew, n_lmul);
            m_sew  = n_sew;
            m_lmul = n_lmul;
         end
      end
   endtask

   always @(negedge clk)
   begin
      if (rstn)
         compare_outputs();
   end

   task automatic drive(input int idx, input logic [31:0] instr, input logic [31:0] rs1);
      @(posedge clk);
      #1;
      if (idx < 0)
         instr_vld_i = '0;
      else
         instr_vld_i = 12'(1) << idx;
      drv_idx        = idx;
      vector_instr_i = instr;
      scalar_rs1_i   = rs1;
   endtask

   task automatic wait_cmd(input logic level, input int limit);
      int n;
      n = 0;
      @(negedge clk);
      while (cmd_vld_o !== level && n < limit)
      begin
         @(negedge clk);
         n++;
      end
      assert (cmd_vld_o === level)
      else
      begin
         $display("timeout in %s: cmd_vld_o did not go to %0b within %0d cycles",
                  test_name, level, limit);
         err_other++;
      end
   endtask

   // one strobe, then idle until the decode window has passed
   task automatic issue(input int idx, input logic [31:0] instr, input logic [31:0] rs1);
      drive(idx, instr, rs1);
      drive(-1, rnd(), rnd());
      wait_cmd(1'b1, 4);
      wait_cmd(1'b0, 4);
   endtask

   task automatic run_cfg_imm();
      logic [2:0]  s;
      logic [2:0]  l;
      logic [4:0]  vs1;
      logic [4:0]  vd;
      test_name = "cfg_imm";
      for (int i = 0; i < 15; i++)
      begin
         s  = 3'(rnd() % 3);
         l  = 3'(rnd() % 7);
         if (l >= 3'd4)
            l = l + 3'd1;               // skip reserved code 4
         vd  = 5'(rnd() % 31 + 1);
         vs1 = (i % 3 == 1) ? 5'(rnd() % 31 + 1) : 5'd0;
         if (i % 3 == 2)
            vd = 5'd0;                  // vl stays
         issue(`VCU_CLS_CFG, {6'd0, l[2], s, l[1:0], vs1, 3'b111, vd, 7'h57},
               {24'd0, 8'(rnd())});
      end
   endtask

   task automatic run_cfg_reg();
      logic [2:0] s;
      logic [2:0] l;
      test_name = "cfg_reg";
      for (int i = 0; i < 4; i++)
      begin
         s = 3'(i % 3);
         l = (i == 3) ? 3'd6 : 3'(i);
         issue(`VCU_CLS_CFG, {2'b10, 10'(rnd()), 5'd0, 3'b111, 5'd3, 7'h57},
               {26'd0, s, l});
      end
   endtask

   task automatic run_arith();
      int cls_tab [5];
      cls_tab = '{`VCU_CLS_MVV, `VCU_CLS_MVX, `VCU_CLS_IVV, `VCU_CLS_IVI, `VCU_CLS_IVX};
      test_name = "arith";
      for (int i = 0; i < 60; i++)
         issue(cls_tab[3'(rnd() % 5)], rnd(), rnd());
   endtask

   task automatic run_mem_red_widen();
      test_name = "mem";
      for (int i = 0; i < 4; i++)
         issue(`VCU_CLS_ISTORE + i, rnd(), rnd());   // istore, store, iload, load
      test_name = "reduction";
      for (int i = 0; i < 8; i++)
      begin
         issue((i % 2 == 1) ? `VCU_CLS_MVX : `VCU_CLS_MVV, {3'd0, 3'(i), 26'(rnd())}, rnd());
         issue(`VCU_CLS_IVV, {3'd6, 3'(i), 26'(rnd())}, rnd());
      end
      test_name = "widen";
      for (int i = 0; i < 8; i++)
      begin
         issue((i % 2 == 1) ? `VCU_CLS_MVX : `VCU_CLS_MVV, {3'd7, 3'(i), 26'(rnd())}, rnd());
         issue(`VCU_CLS_IVX, {3'd6, 3'(i), 26'(rnd())}, rnd());
      end
   endtask

   // back to back slides for each sew
   task automatic run_slides();
      logic [5:0]  f6;
      logic [31:0] fast_amt;
      logic [31:0] rs1;
      int          idx;
      test_name = "slide";
      for (int s = 0; s < 3; s++)
      begin
         issue(`VCU_CLS_CFG, {6'd0, 1'b0, 3'(s), 2'd0, 5'd0, 3'b111, 5'd1, 7'h57}, 32'd0);
         fast_amt = 32'(`VCU_VLANE_NUM << (2 - s));
         for (int j = 0; j < 9; j++)
         begin
            case (j % 3)
               0:       idx = `VCU_CLS_IVI;
               1:       idx = `VCU_CLS_IVX;
               default: idx = `VCU_CLS_MVX;
            endcase
            f6  = (j % 2 == 1) ? 6'h0F : 6'h0E;   // down / up
            rs1 = (j < 5) ? fast_amt : fast_amt + 32'(rnd() % 9 + 1);
            drive(idx, {f6, 26'(rnd())}, rs1);
         end
         drive(-1, rnd(), rnd());
         wait_cmd(1'b0, 4);
      end
   endtask

   initial
   begin
      clk            = 1'b0;
      rstn           = 1'b0;
      instr_vld_i    = '0;
      vector_instr_i = '0;
      scalar_rs1_i   = '0;
      drv_idx        = -1;
      rng            = 32'd87147;
      err_value      = 0;
      err_other      = 0;
      test_name      = "reset";
      repeat (10) @(posedge clk);
      #1;
      rstn = 1'b1;
      @(negedge clk);
      check_val("cmd_vld_o", 32'd0, 32'(cmd_vld_o));
      check_val("sew_o", 32'd2, 32'(sew_o));
      check_val("lmul_o", 32'd0, 32'(lmul_o));
      check_val("vl_o", 32'd128, vl_o);
      run_cfg_imm();
      run_cfg_reg();
      run_arith();
      run_mem_red_widen();
      run_slides();
      $display("value errors %0d, other errors %0d", err_value, err_other);
      if (err_value == 0 && err_other == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire

/* src/vcu_top.sv */
`timescale 1ns/1ns
`default_nettype none
`include "vcu_consts.svh"

module vcu_top
(
   input  logic                     clk,
   input  logic                     rstn,
   input  logic [`VCU_CLS_NUM-1:0]  instr_vld_i,
   input  logic [31:0]              vector_instr_i,
   input  logic [`VCU_XLEN-1:0]     scalar_rs1_i,
   output logic                     cmd_vld_o,      // decoded controls valid
   output logic [2:0]               sew_o,
   output logic [2:0]               lmul_o,
   output logic [`VCU_XLEN-1:0]     vl_o,
   output vcu_pkg::alu_op_e         alu_opmode_o,
   output vcu_pkg::inst_type_e      inst_type_o,
   output vcu_pkg::op2_sel_e        op2_sel_o,
   output logic                     reduction_op_o,
   output logic [1:0]               wdata_width_o,
   output logic                     vector_mask_o,
   output logic [`VCU_XLEN-1:0]     alu_x_data_o,
   output logic [4:0]               alu_imm_o,
   output logic                     up_down_slide_o,
   output logic                     slide_type_o,
   output logic [`VCU_XLEN-1:0]     slide_amount_o
);

   logic [`VCU_CLS_NUM-1:0] cls_q;    // captured class
   logic [31:0]             instr_q;
   logic [`VCU_XLEN-1:0]    rs1_q;
   logic [2:0]              sew;      // current vtype
   logic [2:0]              lmul;

   // capture stage, owns vtype and vl
   vcu_config u_config (
      .clk            (clk),
      .rstn           (rstn),
      .instr_vld_i    (instr_vld_i),
      .vector_instr_i (vector_instr_i),
      .scalar_rs1_i   (scalar_rs1_i),
      .cls_o          (cls_q),
      .instr_o        (instr_q),
      .rs1_o          (rs1_q),
      .sew_o          (sew),
      .lmul_o         (lmul),
      .vl_o           (vl_o)
   );

   vcu_opmode_decode u_opmode (
      .cls_i    (cls_q),
      .instr_i  (instr_q),
      .opmode_o (alu_opmode_o)
   );

   vcu_ctrl_decode u_ctrl (
      .cls_i           (cls_q),
      .instr_i         (instr_q),
      .rs1_i           (rs1_q),
      .sew_i           (sew),
      .inst_type_o     (inst_type_o),
      .op2_sel_o       (op2_sel_o),
      .reduction_op_o  (reduction_op_o),
      .wdata_width_o   (wdata_width_o),
      .vector_mask_o   (vector_mask_o),
      .alu_x_data_o    (alu_x_data_o),
      .alu_imm_o       (alu_imm_o),
      .up_down_slide_o (up_down_slide_o),
      .slide_type_o    (slide_type_o),
      .slide_amount_o  (slide_amount_o)
   );

   assign cmd_vld_o = |cls_q;  // one cycle after each strobe
   assign sew_o     = sew;
   assign lmul_o    = lmul;

endmodule

`default_nettype wire

/* src/vcu_ctrl_decode.sv */
`timescale 1ns/1ns
`default_nettype none
`include "vcu_consts.svh"

module vcu_ctrl_decode
(
   input  logic [`VCU_CLS_NUM-1:0] cls_i,
   input  logic [31:0]             instr_i,
   input  logic [`VCU_XLEN-1:0]    rs1_i,
   input  logic [2:0]              sew_i,          // vtype before any update
   output vcu_pkg::inst_type_e     inst_type_o,
   output vcu_pkg::op2_sel_e       op2_sel_o,
   output logic                    reduction_op_o,
   output logic [1:0]              wdata_width_o,
   output logic                    vector_mask_o,
   output logic [`VCU_XLEN-1:0]    alu_x_data_o,
   output logic [4:0]              alu_imm_o,
   output logic                    up_down_slide_o, // 1 up, 0 down
   output logic                    slide_type_o,    // 1 fast, 0 slow
   output logic [`VCU_XLEN-1:0]    slide_amount_o   // in bytes
);

   logic [5:0] funct6;
   logic       red_chk;
   logic       slide_chk;
   logic       widen_chk;
   logic       fast_slide;

   assign funct6 = instr_i[31:26];

   // reductions: mv funct6 0x00..0x07, iv widening sums 0x30..0x37
   assign red_chk = ((cls_i[`VCU_CLS_MVV] || cls_i[`VCU_CLS_MVX]) && funct6[5:3] == 3'd0) ||
                    (cls_i[`VCU_CLS_IVV] && funct6[5:3] == 3'd6);
   assign slide_chk = !cls_i[`VCU_CLS_CFG] && (funct6 == 6'h0E || funct6 == 6'h0F);
   assign widen_chk = (funct6[5:3] == 3'd6) || (funct6[5:3] == 3'd7);

   // fast when the slide moves exactly one lane row of bytes
   always_comb
   begin
      case (sew_i)
         3'd0:    fast_slide = (rs1_i == `VCU_VLANE_NUM * 4);
         3'd1:    fast_slide = (rs1_i == `VCU_VLANE_NUM * 2);
         3'd2:    fast_slide = (rs1_i == `VCU_VLANE_NUM);
         default: fast_slide = 1'b0;
      endcase
   end

   always_comb
   begin
      if (cls_i[`VCU_CLS_STORE])
         inst_type_o = vcu_pkg::inst_store;
      else if (cls_i[`VCU_CLS_ISTORE])
         inst_type_o = vcu_pkg::inst_istore;
      else if (cls_i[`VCU_CLS_LOAD])
         inst_type_o = vcu_pkg::inst_load;
      else if (cls_i[`VCU_CLS_ILOAD])
         inst_type_o = vcu_pkg::inst_iload;
      else if (red_chk)
         inst_type_o = vcu_pkg::inst_reduction;
      else if (slide_chk)
         inst_type_o = vcu_pkg::inst_slide;
      else if (cls_i[`VCU_CLS_CFG])
         inst_type_o = vcu_pkg::inst_config;
      else
         inst_type_o = vcu_pkg::inst_normal;
   end

   always_comb
   begin
      if (cls_i[`VCU_CLS_IVV] || cls_i[`VCU_CLS_MVV])
         op2_sel_o = vcu_pkg::op2_vector;
      else if (cls_i[`VCU_CLS_IVX] || cls_i[`VCU_CLS_MVX])
         op2_sel_o = vcu_pkg::op2_scalar;
      else if (cls_i[`VCU_CLS_IVI])
         op2_sel_o = vcu_pkg::op2_imm;
      else
         op2_sel_o = vcu_pkg::op2_none;
   end

   assign reduction_op_o = red_chk;
   assign slide_type_o   = fast_slide;

   // slow slides move bytes, widening doubles the element
   assign wdata_width_o = (slide_chk && !fast_slide) ? 2'd1 :
                          widen_chk ? sew_i[1:0] + 2'd2 : sew_i[1:0] + 2'd1;

   assign slide_amount_o = cls_i[`VCU_CLS_IVI] ?
                              {{(`VCU_XLEN-5){1'b0}}, instr_i[19:15]} << sew_i :
                           cls_i[`VCU_CLS_IVX] ? rs1_i << sew_i :
                           {{(`VCU_XLEN-1){1'b0}}, 1'b1} << sew_i; // slide1up/down

   assign up_down_slide_o = (funct6 != 6'h0F);  // 0x0f is slidedown
   assign vector_mask_o   = ~instr_i[25];       // vm=0 means masked
   assign alu_x_data_o    = rs1_i;
   assign alu_imm_o       = instr_i[19:15];     // simm5

endmodule

`default_nettype wire

/* src/vcu_opmode_decode.sv */
`timescale 1ns/1ns
`default_nettype none
`include "vcu_consts.svh"

module vcu_opmode_decode
(
   input  logic [`VCU_CLS_NUM-1:0] cls_i,
   input  logic [31:0]             instr_i,
   output vcu_pkg::alu_op_e        opmode_o
);

   logic [5:0] funct6;
   logic       int_cls;   // opivv, opivi, opivx
   logic       mv_cls;    // opmvv, opmvx

   assign funct6  = instr_i[31:26];
   assign int_cls = |cls_i[`VCU_CLS_IVX:`VCU_CLS_IVV];
   assign mv_cls  = |cls_i[`VCU_CLS_MVX:`VCU_CLS_MVV];

   always_comb
   begin
      opmode_o = vcu_pkg::none_op;
      if (int_cls)
      begin
         case (funct6)
            6'h00:   opmode_o = vcu_pkg::add_op;   // vadd
            6'h02:   opmode_o = vcu_pkg::sub_op;   // vsub
            6'h03:   opmode_o = vcu_pkg::sub_op;   // vrsub
            6'h04:   opmode_o = vcu_pkg::sltu_op;  // vminu
            6'h05:   opmode_o = vcu_pkg::slt_op;   // vmin
            6'h06:   opmode_o = vcu_pkg::sgtu_op;  // vmaxu
            6'h07:   opmode_o = vcu_pkg::sgt_op;   // vmax
            6'h09:   opmode_o = vcu_pkg::and_op;
            6'h0A:   opmode_o = vcu_pkg::or_op;
            6'h0B:   opmode_o = vcu_pkg::xor_op;
            // 0x0c gather, 0x0e/0x0f slides, not alu ops
            6'h10:   opmode_o = vcu_pkg::add_op;   // vadc
            6'h11:   opmode_o = vcu_pkg::add_op;   // vmadc
            6'h12:   opmode_o = vcu_pkg::sub_op;   // vsbc
            6'h13:   opmode_o = vcu_pkg::sub_op;   // vmsbc
            6'h18:   opmode_o = vcu_pkg::seq_op;   // vmseq
            6'h19:   opmode_o = vcu_pkg::sneq_op;  // vmsne
            6'h1A:   opmode_o = vcu_pkg::sltu_op;  // vmsltu
            6'h1B:   opmode_o = vcu_pkg::slt_op;
            6'h1C:   opmode_o = vcu_pkg::sleu_op;  // vmsleu
            6'h1D:   opmode_o = vcu_pkg::sle_op;
            6'h1E:   opmode_o = vcu_pkg::sgtu_op;  // vmsgtu
            6'h1F:   opmode_o = vcu_pkg::sgt_op;
            6'h20:   opmode_o = vcu_pkg::addu_op;  // vsaddu
            6'h21:   opmode_o = vcu_pkg::add_op;   // vsadd
            6'h22:   opmode_o = vcu_pkg::subu_op;  // vssubu
            6'h23:   opmode_o = vcu_pkg::sub_op;   // vssub
            6'h25:   opmode_o = vcu_pkg::sll_op;   // vsll
            6'h27:   opmode_o = vcu_pkg::mul_op;   // vsmul
            6'h28:   opmode_o = vcu_pkg::srl_op;   // vsrl
            6'h29:   opmode_o = vcu_pkg::sra_op;   // vsra
            6'h2A:   opmode_o = vcu_pkg::srl_op;   // vssrl, rounding
            6'h2B:   opmode_o = vcu_pkg::sra_op;   // vssra, rounding
            6'h2C:   opmode_o = vcu_pkg::srl_op;   // vnsrl, narrowing
            6'h2D:   opmode_o = vcu_pkg::sra_op;   // vnsra
            6'h2E:   opmode_o = vcu_pkg::srl_op;   // vnclipu
            6'h2F:   opmode_o = vcu_pkg::srl_op;   // vnclip
            6'h30:   opmode_o = vcu_pkg::add_op;   // vwredsumu
            6'h31:   opmode_o = vcu_pkg::add_op;   // vwredsum
            default: opmode_o = vcu_pkg::none_op;
         endcase
      end
      else if (mv_cls)
      begin
         case (funct6)
            6'h00:   opmode_o = vcu_pkg::add_op;   // vredsum
            6'h01:   opmode_o = vcu_pkg::and_op;   // vredand
            6'h02:   opmode_o = vcu_pkg::or_op;    // vredor
            6'h03:   opmode_o = vcu_pkg::xor_op;   // vredxor
            6'h04:   opmode_o = vcu_pkg::sltu_op;  // vredminu
            6'h05:   opmode_o = vcu_pkg::slt_op;
            6'h06:   opmode_o = vcu_pkg::sgtu_op;  // vredmaxu
            6'h07:   opmode_o = vcu_pkg::sgt_op;
            6'h08:   opmode_o = vcu_pkg::addu_op;  // vaaddu
            6'h09:   opmode_o = vcu_pkg::add_op;   // vaadd
            6'h0A:   opmode_o = vcu_pkg::subu_op;  // vasubu
            6'h0B:   opmode_o = vcu_pkg::sub_op;   // vasub
            // unary group 0x10..0x17 not decoded here
            6'h18:   opmode_o = vcu_pkg::andnot_op; // vmandn
            6'h19:   opmode_o = vcu_pkg::and_op;   // mask logic
            6'h1A:   opmode_o = vcu_pkg::or_op;
            6'h1B:   opmode_o = vcu_pkg::xor_op;
            6'h1C:   opmode_o = vcu_pkg::ornot_op;
            6'h1D:   opmode_o = vcu_pkg::nand_op;
            6'h1E:   opmode_o = vcu_pkg::nor_op;
            6'h1F:   opmode_o = vcu_pkg::xnor_op;
            6'h24:   opmode_o = vcu_pkg::mulhu_op;
            6'h25:   opmode_o = vcu_pkg::mul_op;   // vmul
            6'h26:   opmode_o = vcu_pkg::mulhsu_op;
            6'h27:   opmode_o = vcu_pkg::mulh_op;
            6'h29:   opmode_o = vcu_pkg::mul_add_op; // vmadd
            6'h2B:   opmode_o = vcu_pkg::mul_sub_op; // vnmsub
            6'h2D:   opmode_o = vcu_pkg::mul_add_op; // vmacc
            6'h2F:   opmode_o = vcu_pkg::mul_sub_op; // vnmsac
            6'h30:   opmode_o = vcu_pkg::addu_op;  // vwaddu
            6'h31:   opmode_o = vcu_pkg::add_op;   // vwadd
            6'h32:   opmode_o = vcu_pkg::subu_op;  // vwsubu
            6'h33:   opmode_o = vcu_pkg::sub_op;   // vwsub
            6'h34:   opmode_o = vcu_pkg::addu_op;  // vwaddu.w
            6'h35:   opmode_o = vcu_pkg::add_op;
            6'h36:   opmode_o = vcu_pkg::subu_op;  // vwsubu.w
            6'h37:   opmode_o = vcu_pkg::sub_op;
            6'h38:   opmode_o = vcu_pkg::mulu_op;  // vwmulu
            6'h3A:   opmode_o = vcu_pkg::mulsu_op; // vwmulsu
            6'h3B:   opmode_o = vcu_pkg::mul_op;   // vwmul
            6'h3C:   opmode_o = vcu_pkg::mulu_add_op;  // vwmaccu
            6'h3D:   opmode_o = vcu_pkg::mul_add_op;   // vwmacc
            6'h3E:   opmode_o = vcu_pkg::mulus_add_op; // vwmaccus
            6'h3F:   opmode_o = vcu_pkg::mulsu_add_op; // vwmaccsu
            default: opmode_o = vcu_pkg::none_op;
         endcase
      end
   end

endmodule

`default_nettype wire

/* src/vcu_config.sv */
`timescale 1ns/1ns
`default_nettype none
`include "vcu_consts.svh"

module vcu_config
(
   input  logic                     clk,
   input  logic                     rstn,
   input  logic [`VCU_CLS_NUM-1:0]  instr_vld_i,    // one-hot class, one cycle
   input  logic [31:0]              vector_instr_i,
   input  logic [`VCU_XLEN-1:0]     scalar_rs1_i,
   output logic [`VCU_CLS_NUM-1:0]  cls_o,          // captured class
   output logic [31:0]              instr_o,
   output logic [`VCU_XLEN-1:0]     rs1_o,
   output logic [2:0]               sew_o,          // current vtype
   output logic [2:0]               lmul_o,
   output logic [`VCU_XLEN-1:0]     vl_o
);

   logic [`VCU_CLS_NUM-1:0] cls_q;
   logic [31:0]             instr_q;
   logic [`VCU_XLEN-1:0]    rs1_q;
   logic [2:0]              sew_q, sew_nxt;
   logic [2:0]              lmul_q, lmul_nxt;
   logic [`VCU_XLEN-1:0]    vl_q, vl_nxt;
   logic [`VCU_XLEN-1:0]    vlmax_nxt;

   // elements per register group, fractional lmul codes 5..7, code 4 reserved
   function automatic logic [`VCU_XLEN-1:0] vlmax_f(input logic [2:0] sew_v,
                                                    input logic [2:0] lmul_v);
      logic [`VCU_XLEN-1:0] base;
      base = `VCU_VLEN / 8; // bytes per register
      base = base >> sew_v; // elements per register
      if (!lmul_v[2])
         return base << lmul_v;
      else if (lmul_v == 3'd4)
         return '0;
      else
         return base >> (4'd8 - {1'b0, lmul_v}); // lmul 1/8 .. 1/2
   endfunction

   // instruction and operand, captured every cycle
   always_ff @(posedge clk)
   begin
      instr_q <= vector_instr_i;
      rs1_q   <= scalar_rs1_i;
   end

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         cls_q  <= '0;
         sew_q  <= 3'd2;                    // e32
         lmul_q <= 3'd0;                    // m1
         vl_q   <= vlmax_f(3'd2, 3'd0);     // 128 for a 4096 bit vlen
      end
      else
      begin
         cls_q <= instr_vld_i;
         if (cls_q[`VCU_CLS_CFG])           // config captured last edge
         begin
            sew_q  <= sew_nxt;
            lmul_q <= lmul_nxt;
            vl_q   <= vl_nxt;
         end
      end
   end

   // new vtype source
   always_comb
   begin
      if (instr_q[31:30] == 2'b10)          // vsetvl, vtype in rs1
      begin
         lmul_nxt = rs1_q[2:0];
         sew_nxt  = rs1_q[5:3];
      end
      else                                  // vsetvli, vtype in zimm
      begin
         lmul_nxt = {instr_q[25], instr_q[21:20]};
         sew_nxt  = instr_q[24:22];
      end
   end

   assign vlmax_nxt = vlmax_f(sew_nxt, lmul_nxt);

   // avl from rs1, else vlmax when vd set, else keep
   assign vl_nxt = (instr_q[19:15] != 5'd0) ? rs1_q :
                   (instr_q[11:7] != 5'd0)  ? vlmax_nxt : vl_q;

   assign cls_o   = cls_q;
   assign instr_o = instr_q;
   assign rs1_o   = rs1_q;
   assign sew_o   = sew_q;
   assign lmul_o  = lmul_q;
   assign vl_o    = vl_q;

endmodule

`default_nettype wire

/* src/vcu_pkg.sv */
`default_nettype none
`include "vcu_consts.svh"

package vcu_pkg;

   // alu operations, none must stay at zero
   typedef enum logic [`VCU_OPMODE_W-1:0] {
      none_op = 0,
      add_op, addu_op, sub_op, subu_op,
      sll_op, srl_op, sra_op,
      and_op, or_op, xor_op, andnot_op, ornot_op, nand_op, nor_op, xnor_op,
      seq_op, sneq_op, slt_op, sltu_op, sle_op, sleu_op, sgt_op, sgtu_op,
      mul_op, mulu_op, mulsu_op, mulh_op, mulhu_op, mulhsu_op,
      mul_add_op,   // multiply-accumulate
      mul_sub_op,
      mulu_add_op,
      mulus_add_op,
      mulsu_add_op
   } alu_op_e;

   // instruction type seen by the lane control units
   typedef enum logic [2:0] {
      inst_normal    = 3'd0,
      inst_reduction = 3'd1,
      inst_store     = 3'd2,
      inst_istore    = 3'd3, // indexed store
      inst_load      = 3'd4,
      inst_iload     = 3'd5, // indexed load
      inst_slide     = 3'd6,
      inst_config    = 3'd7
   } inst_type_e;

   // alu operand 2 source
   typedef enum logic [1:0] {
      op2_vector = 2'd0, // vs1 from vrf
      op2_scalar = 2'd1, // rs1 from scalar core
      op2_imm    = 2'd2, // simm5 field
      op2_none   = 2'd3
   } op2_sel_e;

endpackage

`default_nettype wire

/* src/vcu_consts.svh */
`ifndef VCU_CONSTS_SVH
`define VCU_CONSTS_SVH

`define VCU_VLEN       4096 // vector register length, bits
`define VCU_VLANE_NUM  16   // lane count, sets the fast slide amounts
`define VCU_XLEN       32   // scalar operand, vl and slide amount width

// one-hot class strobe from the scheduler
`define VCU_CLS_NUM    12
`define VCU_CLS_ISTORE 2    // indexed store
`define VCU_CLS_STORE  3
`define VCU_CLS_ILOAD  4    // indexed load
`define VCU_CLS_LOAD   5
`define VCU_CLS_MVV    6
`define VCU_CLS_MVX    7
`define VCU_CLS_IVV    8
`define VCU_CLS_IVI    9
`define VCU_CLS_IVX    10
`define VCU_CLS_CFG    11   // vsetvl / vsetvli

`define VCU_OPMODE_W   9    // alu opmode width
`endif
